/* logic/rob_pkg.sv */
// rv32i only; tags are plain entry indices, so rob_sz must stay a power of two
`default_nettype none

package rob_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int rob_sz       = 8;
    localparam int rob_tag_bits = $clog2(rob_sz);
    localparam int xlen         = 32;

    typedef logic [4:0]              reg_addr_t;
    typedef logic [rob_tag_bits-1:0] rob_tag_t;
    typedef logic [xlen-1:0]         word_t;
    typedef logic [6:0]              opcode_t;

    // rv32 major opcodes
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_branch = 7'b1100011;

    // per entry life cycle
    typedef enum logic [1:0] {empty, busy, ready} rob_state_t;

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        reg_addr_t dest_reg;
    } dispatch_rob_packet_t;

    // valid doubles as the accept
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } rob_dispatch_packet_t;

    // stores put the address in value and the data in store_data
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        word_t    store_data;
    } cdb_rob_packet_t;

    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;
        logic      reg_valid;
        reg_addr_t dest_reg;
        word_t     value;
        logic      mem_valid;
        word_t     mem_addr;
        word_t     mem_data;
    } rob_retire_packet_t;

    // opcode classes
    function automatic logic writes_register(input opcode_t opcode);
        return opcode inside {op_load, op_imm, op_reg, op_jal, op_jalr, op_lui, op_auipc};
    endfunction

    function automatic logic writes_memory(input opcode_t opcode);
        return opcode == op_store;
    endfunction

endpackage

`default_nettype wire

/* logic/arch_regfile.sv */
// one write port, one combinational read port; x0 is hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  logic               clock,
    input  logic               reset,
    input  logic               write_enable,
    input  rob_pkg::reg_addr_t write_addr,
    input  rob_pkg::word_t     write_data,
    input  rob_pkg::reg_addr_t read_addr,
    output rob_pkg::word_t     read_data
);
    import rob_pkg::*;

    word_t regs [32];

    // committed state, so it starts clean
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            // x0 writes are dropped here
            regs[write_addr] <= write_data;
        end
    end

    // new value visible right after the write edge
    assign read_data = (read_addr == '0) ? '0 : regs[read_addr];

endmodule

`default_nettype wire

/* logic/reorder_buffer.sv */
// one dispatch, one cdb write and one retire per cycle; flush drops every entry in one cycle
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                          clock,
    input  logic                          reset,
    input  rob_pkg::dispatch_rob_packet_t dispatch_in,
    output rob_pkg::rob_dispatch_packet_t dispatch_out,
    input  rob_pkg::cdb_rob_packet_t      cdb_in,
    input  logic                          read_enable_a,
    input  logic                          read_enable_b,
    input  rob_pkg::rob_tag_t             read_tag_a,
    input  rob_pkg::rob_tag_t             read_tag_b,
    output rob_pkg::word_t                read_value_a,
    output rob_pkg::word_t                read_value_b,
    input  logic                          retire_request,
    input  logic                          flush,
    output rob_pkg::rob_retire_packet_t   retire_out,
    output logic                          full
);
    import rob_pkg::*;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    rob_state_t entry_state [rob_sz];
    opcode_t    entry_opcode [rob_sz];
    reg_addr_t  entry_dest [rob_sz];
    word_t      entry_value [rob_sz];
    word_t      entry_store_data [rob_sz];

    // extra msb is the wrap bit
    logic [rob_tag_bits:0] head;
    logic [rob_tag_bits:0] tail;

    rob_tag_t head_idx;
    rob_tag_t tail_idx;
    logic     do_dispatch;
    logic     do_retire;
    logic     head_reg;
    logic     head_mem;

    assign head_idx = head[rob_tag_bits-1:0];
    assign tail_idx = tail[rob_tag_bits-1:0];

    // same slot on a different lap
    assign full = (head_idx == tail_idx) && (head[rob_tag_bits] != tail[rob_tag_bits]);

    //////////////////////////////////////////////////
    // dispatch and operand reads
    //////////////////////////////////////////////////
    // no accept in the flush cycle because the flush branch drops the new entry
    assign do_dispatch      = dispatch_in.valid && !full && !flush;
    assign dispatch_out.valid = do_dispatch;
    assign dispatch_out.tag   = tail_idx;

    assign read_value_a = read_enable_a ? entry_value[read_tag_a] : '0;
    assign read_value_b = read_enable_b ? entry_value[read_tag_b] : '0;

    //////////////////////////////////////////////////
    // retire packet
    //////////////////////////////////////////////////
    assign do_retire = retire_request && (entry_state[head_idx] == ready) && !flush;
    assign head_reg  = writes_register(entry_opcode[head_idx]);
    assign head_mem  = writes_memory(entry_opcode[head_idx]);

    always_comb begin
        retire_out = '0;
        if (do_retire) begin
            retire_out.valid     = 1'b1;
            retire_out.tag       = head_idx;
            // branches fall through with both class bits low
            retire_out.reg_valid = head_reg;
            retire_out.dest_reg  = entry_dest[head_idx];
            retire_out.value     = entry_value[head_idx];
            retire_out.mem_valid = head_mem;
            retire_out.mem_addr  = entry_value[head_idx];
            retire_out.mem_data  = entry_store_data[head_idx];
        end
    end

    //////////////////////////////////////////////////
    // state and pointers
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rob_sz; i++) begin
                entry_state[i] <= empty;
            end
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            // mispredict drops every entry and keeps tail where it is
            for (int i = 0; i < rob_sz; i++) begin
                entry_state[i] <= empty;
            end
            head <= tail;
        end else begin
            if (do_dispatch) begin
                entry_state[tail_idx] <= busy;
                tail <= tail + 1'b1;
            end
            if (cdb_in.valid) begin
                entry_state[cdb_in.tag] <= ready;
            end
            // head is ready so it cannot collide with the cdb slot
            if (do_retire) begin
                entry_state[head_idx] <= empty;
                head <= head + 1'b1;
            end
        end
    end

    // payload follows the state writes
    always_ff @(posedge clock) begin
        if (do_dispatch) begin
            entry_opcode[tail_idx] <= dispatch_in.opcode;
            entry_dest[tail_idx]   <= dispatch_in.dest_reg;
        end
        if (cdb_in.valid) begin
            entry_value[cdb_in.tag]      <= cdb_in.value;
            entry_store_data[cdb_in.tag] <= cdb_in.store_data;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    // execution must only complete tags that dispatch handed out
    a_cdb_live_entry : assert property (@(posedge clock) disable iff (reset)
        cdb_in.valid |-> entry_state[cdb_in.tag] != empty)
        else $error("cdb write to empty entry %0d", cdb_in.tag);

    // pointers and entry states must agree on which slot is free
    a_dispatch_to_empty : assert property (@(posedge clock) disable iff (reset)
        do_dispatch |-> entry_state[tail_idx] == empty)
        else $error("dispatch into live entry %0d", tail_idx);

endmodule

`default_nettype wire

/* logic/retire_stage.sv */
// one store on the bus at a time; the slave must ack every cycle it sees
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  rob_pkg::rob_retire_packet_t retire_in,
    output logic                        retire_request,
    output logic                        reg_write,
    output rob_pkg::reg_addr_t          reg_addr,
    output rob_pkg::word_t              reg_data,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output rob_pkg::word_t              wb_adr,
    output rob_pkg::word_t              wb_dat_w,
    output logic [3:0]                  wb_sel,
    input  logic                        wb_ack
);
    import rob_pkg::*;

    typedef enum logic {idle, store_pending} retire_state_t;

    retire_state_t state;
    logic          start_store;

    // head is held back while a store is out
    assign retire_request = (state == idle);
    assign start_store    = retire_in.valid && retire_in.mem_valid;

    // register results go straight through
    assign reg_write = retire_in.valid && retire_in.reg_valid;
    assign reg_addr  = retire_in.dest_reg;
    assign reg_data  = retire_in.value;

    // write only with all four byte lanes
    assign wb_we  = 1'b1;
    assign wb_sel = 4'hf;

    //////////////////////////////////////////////////
    // store fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start_store) begin
                        state  <= store_pending;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                store_pending: begin
                    // classic cycle ends on the first ack edge
                    if (wb_ack) begin
                        state  <= idle;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
            endcase
        end
    end

    // address and data held for the whole cycle
    always_ff @(posedge clock) begin
        if (state == idle && start_store) begin
            wb_adr   <= retire_in.mem_addr;
            wb_dat_w <= retire_in.mem_data;
        end
    end

    // the slave may only answer a strobe of an open cycle
    a_ack_in_cycle : assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack outside a bus cycle");

endmodule

`default_nettype wire

/* logic/rob_core.sv */
// completion side only; dispatch, execution and the memory slave live outside
`timescale 1ns/1ps
`default_nettype none

module rob_core (
    input  logic                          clock,
    input  logic                          reset,
    input  rob_pkg::dispatch_rob_packet_t dispatch_in,
    output rob_pkg::rob_dispatch_packet_t dispatch_out,
    input  rob_pkg::cdb_rob_packet_t      cdb_in,
    input  logic                          read_enable_a,
    input  logic                          read_enable_b,
    input  rob_pkg::rob_tag_t             read_tag_a,
    input  rob_pkg::rob_tag_t             read_tag_b,
    output rob_pkg::word_t                read_value_a,
    output rob_pkg::word_t                read_value_b,
    input  logic                          flush,
    output logic                          full,
    input  rob_pkg::reg_addr_t            arch_read_addr,
    output rob_pkg::word_t                arch_read_data,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output rob_pkg::word_t                wb_adr,
    output rob_pkg::word_t                wb_dat_w,
    output logic [3:0]                    wb_sel,
    input  logic                          wb_ack
);
    import rob_pkg::*;

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////
    rob_retire_packet_t retire_pkt;
    logic               retire_request;
    logic               reg_write;
    reg_addr_t          reg_addr;
    word_t              reg_data;

    reorder_buffer u_rob (
        .clock          (clock),
        .reset          (reset),
        .dispatch_in    (dispatch_in),
        .dispatch_out   (dispatch_out),
        .cdb_in         (cdb_in),
        .read_enable_a  (read_enable_a),
        .read_enable_b  (read_enable_b),
        .read_tag_a     (read_tag_a),
        .read_tag_b     (read_tag_b),
        .read_value_a   (read_value_a),
        .read_value_b   (read_value_b),
        .retire_request (retire_request),
        .flush          (flush),
        .retire_out     (retire_pkt),
        .full           (full)
    );

    // head consumer, register writes and the store master
    retire_stage u_retire (
        .clock          (clock),
        .reset          (reset),
        .retire_in      (retire_pkt),
        .retire_request (retire_request),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_data       (reg_data),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .wb_ack         (wb_ack)
    );

    arch_regfile u_regfile (
        .clock        (clock),
        .reset        (reset),
        .write_enable (reg_write),
        .write_addr   (reg_addr),
        .write_data   (reg_data),
        .read_addr    (arch_read_addr),
        .read_data    (arch_read_data)
    );

endmodule

`default_nettype wire

/* dv/rob_core_tb.sv */
// needs a simulator with timing support; x31 is kept as the drain marker register
`timescale 1ns/1ps
`default_nettype none

module rob_core_tb;
    import rob_pkg::*;

    localparam int wait_limit = 200;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t dest;
        rob_tag_t  tag;
        word_t     value;
        word_t     sdata;
    } inst_t;

    typedef struct packed {
        logic      reg_we;
        reg_addr_t dest;
        word_t     value;
        logic      mem_we;
        word_t     addr;
        word_t     data;
    } effect_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic                 clock;
    logic                 reset;
    dispatch_rob_packet_t dispatch_in;
    rob_dispatch_packet_t dispatch_out;
    cdb_rob_packet_t      cdb_in;
    logic                 read_enable_a;
    logic                 read_enable_b;
    rob_tag_t             read_tag_a;
    rob_tag_t             read_tag_b;
    word_t                read_value_a;
    word_t                read_value_b;
    logic                 flush;
    logic                 full;
    reg_addr_t            arch_read_addr;
    word_t                arch_read_data;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    word_t                wb_adr;
    word_t                wb_dat_w;
    logic [3:0]           wb_sel;
    logic                 wb_ack;

    // scoreboard
    word_t   exp_regs [32];
    store_t  exp_stores [$];
    store_t  bus_stores [$];
    inst_t   prog [$];
    opcode_t reg_ops [7] = '{op_load, op_imm, op_reg, op_jal, op_jalr, op_lui, op_auipc};

    word_t rand_state = 32'd87;
    int    errors = 0;
    int    checks = 0;
    int    store_errors = 0;
    int    store_checks = 0;
    int    bus_checked = 0;
    int    tests = 0;
    int    errs_at_start = 0;
    // accepted dispatches since reset, the tail slot follows it
    int    dispatched = 0;
    logic  aborted = 1'b0;

    rob_core UUT (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rand_state = xorshift(rand_state);
        return rand_state;
    endfunction

    function automatic int rand_below(input int n);
        word_t r;
        r = next_rand();
        return int'(r % word_t'(n));
    endfunction

    // what retiring one instruction should do to the machine state
    function automatic effect_t expected_effect(input opcode_t op, input reg_addr_t dest,
                                                input word_t value, input word_t sdata);
        effect_t e;
        e.reg_we = 1'b0;
        e.mem_we = 1'b0;
        e.dest   = dest;
        e.value  = value;
        e.addr   = value;
        e.data   = sdata;
        case (op)
            op_load, op_imm, op_reg, op_jal, op_jalr, op_lui, op_auipc: e.reg_we = (dest != 0);
            op_store: e.mem_we = 1'b1;
            default: e.reg_we = 1'b0;
        endcase
        return e;
    endfunction

    task automatic step_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_sel(input logic [3:0] got, input logic [3:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // only the compare process calls this one
    task automatic check_store(input store_t got, input store_t exp, input int n);
        store_checks++;
        if (got !== exp) begin
            $display("ERR %0t: store %0d got %h/%h expected %h/%h", $time, n,
                     got.addr, got.data, exp.addr, exp.data);
            store_errors++;
        end
    endtask

    task automatic apply_effect(input inst_t p);
        effect_t e;
        store_t  s;
        e = expected_effect(p.op, p.dest, p.value, p.sdata);
        if (e.reg_we) begin
            exp_regs[e.dest] = e.value;
        end
        if (e.mem_we) begin
            s.addr = e.addr;
            s.data = e.data;
            exp_stores.push_back(s);
        end
    endtask

    task automatic expect_program();
        foreach (prog[i]) begin
            apply_effect(prog[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic try_dispatch(input opcode_t op, input reg_addr_t dest,
                                output logic ok, output rob_tag_t tag);
        dispatch_in.valid    = 1'b1;
        dispatch_in.opcode   = op;
        dispatch_in.dest_reg = dest;
        #1;
        ok  = dispatch_out.valid;
        tag = dispatch_out.tag;
        if (ok) begin
            dispatched++;
        end
        step_cycle();
        dispatch_in = '0;
    endtask

    // retries until accepted
    // value is what the cdb will bring later
    task automatic issue(input opcode_t op, input reg_addr_t dest, input word_t value,
                         input word_t sdata, output int idx);
        inst_t    p;
        logic     ok;
        rob_tag_t tag;
        int       n;
        idx = -1;
        ok  = 1'b0;
        n   = 0;
        while (!ok && n < wait_limit) begin
            try_dispatch(op, dest, ok, tag);
            n++;
        end
        if (ok) begin
            p.op    = op;
            p.dest  = dest;
            p.tag   = tag;
            p.value = value;
            p.sdata = sdata;
            prog.push_back(p);
            idx = prog.size() - 1;
        end else begin
            report_timeout("dispatch was never accepted");
        end
    endtask

    task automatic complete(input int idx);
        cdb_in.valid      = 1'b1;
        cdb_in.tag        = prog[idx].tag;
        cdb_in.value      = prog[idx].value;
        cdb_in.store_data = prog[idx].sdata;
        step_cycle();
        cdb_in = '0;
    endtask

    task automatic complete_shuffled();
        int order [$];
        int j;
        int t;
        for (int i = 0; i < prog.size(); i++) begin
            order.push_back(i);
        end
        for (int i = prog.size() - 1; i > 0; i--) begin
            j        = rand_below(i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[k]) begin
            complete(order[k]);
        end
    endtask

    // youngest marker write to x31
    // once it lands everything older has retired
    task automatic drain_buffer();
        word_t marker;
        int    idx;
        int    n;
        logic  landed;
        marker = next_rand();
        if (marker == exp_regs[31]) begin
            marker = ~marker;
        end
        issue(op_lui, 5'd31, marker, '0, idx);
        if (idx < 0) begin
            return;
        end
        apply_effect(prog[idx]);
        complete(idx);
        arch_read_addr = 5'd31;
        #1;
        n = 0;
        while (arch_read_data !== marker && n < wait_limit) begin
            @(posedge clock);
            #2;
            n++;
        end
        landed = (arch_read_data === marker);
        step_cycle();
        if (!landed) begin
            report_timeout("buffer did not drain");
        end
        n = 0;
        while ((bus_checked < exp_stores.size() || wb_cyc) && n < wait_limit) begin
            step_cycle();
            n++;
        end
        if (bus_checked < exp_stores.size()) begin
            report_timeout("expected stores never reached the bus");
        end
    endtask

    // one register per cycle through the external read port
    task automatic check_regfile(input string what);
        for (int i = 0; i < 32; i++) begin
            arch_read_addr = reg_addr_t'(i);
            #1;
            check_word(arch_read_data, exp_regs[i], $sformatf("%s x%0d", what, i));
            step_cycle();
        end
    endtask

    task automatic end_test(input string name);
        int now_errs;
        now_errs = errors + store_errors;
        tests++;
        if (now_errs == errs_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, now_errs - errs_at_start);
        end
        errs_at_start = now_errs;
    endtask

    //////////////////////////////////////////////////
    // wishbone slave and store compare
    //////////////////////////////////////////////////
    initial begin : wishbone_slave
        word_t  ack_state;
        int     wait_left;
        logic   in_cycle;
        store_t s;
        wb_ack    = 1'b0;
        ack_state = 32'd87;
        wait_left = 0;
        in_cycle  = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (wb_ack) begin
                // master saw ack on this edge
                wb_ack   = 1'b0;
                in_cycle = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!in_cycle) begin
                    in_cycle  = 1'b1;
                    ack_state = xorshift(ack_state);
                    wait_left = int'(ack_state[1:0]);
                end
                if (wait_left == 0) begin
                    // every store is a full word write
                    check_flag(wb_we, 1'b1, "wb_we on store");
                    check_sel(wb_sel, 4'hf, "wb_sel on store");
                    s.addr = wb_adr;
                    s.data = wb_dat_w;
                    bus_stores.push_back(s);
                    wb_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // bus stores must match expected stores in program order
    initial begin : store_compare
        forever begin
            @(negedge clock);
            while (bus_checked < bus_stores.size()) begin
                if (bus_checked < exp_stores.size()) begin
                    check_store(bus_stores[bus_checked], exp_stores[bus_checked], bus_checked);
                end else begin
                    $display("unexpected store to %h at %0t, no store was left to retire",
                             bus_stores[bus_checked].addr, $time);
                    store_errors++;
                end
                bus_checked++;
            end
        end
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic test_reset_state();
        check_flag(full, 1'b0, "full after reset");
        check_flag(wb_cyc, 1'b0, "wb_cyc after reset");
        check_flag(wb_stb, 1'b0, "wb_stb after reset");
        check_regfile("reset");
        end_test("reset state");
    endtask

    task automatic test_out_of_order();
        int idx;
        prog.delete();
        // few destinations so later writes overwrite earlier ones
        for (int i = 0; i < 6; i++) begin
            issue(reg_ops[rand_below(7)], reg_addr_t'(1 + rand_below(3)), next_rand(), '0, idx);
        end
        expect_program();
        complete_shuffled();
        drain_buffer();
        check_regfile("in-order retire");
        end_test("out-of-order completion");
    endtask

    task automatic test_full();
        inst_t    p;
        logic     ok;
        rob_tag_t tag;
        int       tags_before;
        int       accepted;
        prog.delete();
        accepted    = 0;
        tags_before = dispatched;
        for (int i = 0; i < rob_sz + 2; i++) begin
            p.op    = op_imm;
            p.dest  = reg_addr_t'(4 + i % 4);
            p.value = next_rand();
            p.sdata = '0;
            try_dispatch(p.op, p.dest, ok, tag);
            if (ok) begin
                // tags wrap around the buffer in dispatch order
                check_tag(tag, rob_tag_t'(tags_before + accepted), "dispatch tag");
                p.tag = tag;
                prog.push_back(p);
                accepted++;
            end
        end
        check_flag(full, 1'b1, "full with no completions");
        check_word(word_t'(accepted), word_t'(rob_sz), "accepted dispatch count");
        expect_program();
        complete_shuffled();
        drain_buffer();
        check_flag(full, 1'b0, "full after drain");
        check_regfile("after full");
        end_test("full and back-pressure");
    endtask

    task automatic test_stores();
        int idx;
        prog.delete();
        for (int i = 0; i < 7; i++) begin
            if (i < 6 && (i == 0 || rand_below(2) == 0)) begin
                issue(op_store, 5'd0, next_rand() & 32'hffff_fffc, next_rand(), idx);
            end else begin
                issue(op_reg, reg_addr_t'(1 + rand_below(8)), next_rand(), '0, idx);
            end
        end
        expect_program();
        complete_shuffled();
        drain_buffer();
        check_regfile("around stores");
        end_test("stores");
    endtask

    task automatic test_opcode_classes();
        int idx;
        prog.delete();
        issue(op_branch, 5'd6, next_rand(), '0, idx);
        issue(op_reg, 5'd0, next_rand(), '0, idx);
        issue(op_imm, 5'd0, next_rand(), '0, idx);
        issue(op_jal, 5'd0, next_rand(), '0, idx);
        issue(op_branch, 5'd2, next_rand(), '0, idx);
        expect_program();
        complete_shuffled();
        drain_buffer();
        check_regfile("branches and x0");
        end_test("opcode classes");
    endtask

    task automatic test_operand_reads();
        int idx;
        prog.delete();
        // first entry stays busy and holds the second one in the buffer
        issue(op_reg, 5'd9, next_rand(), '0, idx);
        issue(op_imm, 5'd10, next_rand(), '0, idx);
        if (prog.size() == 2) begin
            expect_program();
            complete(1);
            read_enable_a = 1'b1;
            read_enable_b = 1'b1;
            read_tag_a    = prog[1].tag;
            read_tag_b    = prog[1].tag;
            #1;
            check_word(read_value_a, prog[1].value, "read port a");
            check_word(read_value_b, prog[1].value, "read port b");
            read_enable_a = 1'b0;
            read_enable_b = 1'b0;
            #1;
            check_word(read_value_a, '0, "read port a disabled");
            check_word(read_value_b, '0, "read port b disabled");
            step_cycle();
            complete(0);
        end
        drain_buffer();
        check_regfile("operand reads");
        end_test("operand reads");
    endtask

    task automatic test_flush();
        int idx;
        prog.delete();
        issue(op_reg, 5'd11, next_rand(), '0, idx);
        issue(op_store, 5'd0, next_rand() & 32'hffff_fffc, next_rand(), idx);
        issue(op_imm, 5'd12, next_rand(), '0, idx);
        issue(op_reg, 5'd13, next_rand(), '0, idx);
        // head left busy so nothing retires before the flush
        if (prog.size() == 4) begin
            complete(1);
            complete(2);
            complete(3);
        end
        flush                = 1'b1;
        dispatch_in.valid    = 1'b1;
        dispatch_in.opcode   = op_imm;
        dispatch_in.dest_reg = 5'd14;
        #1;
        check_flag(dispatch_out.valid, 1'b0, "accept during flush");
        step_cycle();
        flush       = 1'b0;
        dispatch_in = '0;
        check_flag(full, 1'b0, "full after flush");
        check_flag(wb_cyc, 1'b0, "bus idle after flush");
        prog.delete();
        issue(op_imm, 5'd14, next_rand(), '0, idx);
        if (idx >= 0) begin
            expect_program();
            complete(idx);
        end
        drain_buffer();
        check_regfile("after flush");
        end_test("flush");
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin : main_sequence
        reset          = 1'b1;
        dispatch_in    = '0;
        cdb_in         = '0;
        read_enable_a  = 1'b0;
        read_enable_b  = 1'b0;
        read_tag_a     = '0;
        read_tag_b     = '0;
        flush          = 1'b0;
        arch_read_addr = '0;
        for (int i = 0; i < 32; i++) begin
            exp_regs[i] = '0;
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        test_reset_state();
        if (!aborted) test_out_of_order();
        if (!aborted) test_full();
        if (!aborted) test_stores();
        if (!aborted) test_opcode_classes();
        if (!aborted) test_operand_reads();
        if (!aborted) test_flush();

        $display("tests %0d, checks %0d, errors %0d", tests, checks + store_checks,
                 errors + store_errors);
        if (errors + store_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rob_core.f */
logic/rob_pkg.sv
logic/arch_regfile.sv
logic/reorder_buffer.sv
logic/retire_stage.sv
logic/rob_core.sv
dv/rob_core_tb.sv

/* Makefile */
# verilator build and run of rob_core_tb
.PHONY: all run clean

all: run

obj_dir/Vrob_core_tb: rob_core.f $(wildcard logic/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module rob_core_tb -f rob_core.f -o Vrob_core_tb

run: obj_dir/Vrob_core_tb
	obj_dir/Vrob_core_tb > sim.log; cat sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
